// File: convolution_filter.sv
module convolution_filter #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int W_FRAC     = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Camera pixel stream
    input  logic                  x_valid,
    output logic                  x_ready,
    input  vision_pkg::pixel_t    x_data,

    // Coefficients, row-major
    input  vision_pkg::kernel_t   kernel,

    // Filtered stream
    output logic                  y_valid,
    input  logic                  y_ready,
    output vision_pkg::pix_beat_t y_beat
);

    // Frame position of the incoming pixel
    typedef logic [$clog2(IMG_WIDTH)-1:0] col_t;
    typedef logic [$clog2(IMG_HEIGHT)-1:0] row_t;
    // Wide enough for nine 8x8 signed products
    typedef logic signed [19:0] sum_t;

    col_t col;
    row_t row;

    // Row above and two rows above, indexed by column
    vision_pkg::pixel_t line0 [IMG_WIDTH];
    vision_pkg::pixel_t line1 [IMG_WIDTH];

    // Window, [row][col], row 0 is oldest
    vision_pkg::pixel_t win   [0:2][0:2];
    vision_pkg::pixel_t w_nxt [0:2][0:2];

    logic               ready_en;
    logic               x_fire;
    logic               win_done;
    sum_t               acc;
    sum_t               scaled;
    vision_pkg::pixel_t clamped;

    // ==============================
    // Handshake
    // ==============================

    // Held low for one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    // Room when output register empty or draining
    assign x_ready = ready_en && (!y_valid || y_ready);
    assign x_fire  = x_valid && x_ready;

    // Valid window once two rows and two columns are in
    assign win_done = (row >= row_t'(2)) && (col >= col_t'(2));

    // ==============================
    // Position counters
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (x_fire) begin
            if (col == col_t'(IMG_WIDTH - 1)) begin
                col <= '0;
                // Wrap to next frame after last row
                if (row == row_t'(IMG_HEIGHT - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + row_t'(1);
                end
            end else begin
                col <= col + col_t'(1);
            end
        end
    end

    // ==============================
    // Line buffers and window
    // ==============================

    // Shift left, new column from line buffers plus live pixel
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            w_nxt[r][0] = win[r][1];
            w_nxt[r][1] = win[r][2];
        end
        w_nxt[0][2] = line1[col];
        w_nxt[1][2] = line0[col];
        w_nxt[2][2] = x_data;
    end

    always_ff @(posedge clk) begin
        if (x_fire) begin
            line1[col] <= line0[col];
            line0[col] <= x_data;
            win        <= w_nxt;
        end
    end

    // ==============================
    // MAC, scale, clamp
    // ==============================

    // Correlation, kernel[3*r+c] weights window[r][c]
    always_comb begin
        acc = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                acc = acc + sum_t'($signed({1'b0, w_nxt[r][c]}))
                          * sum_t'(kernel[r*3+c]);
            end
        end
    end

    // Arithmetic shift keeps sign for clamping
    assign scaled = acc >>> W_FRAC;

    always_comb begin
        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > sum_t'(255)) begin
            clamped = 8'hff;
        end else begin
            clamped = scaled[7:0];
        end
    end

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_valid <= 1'b0;
        end else if (x_fire && win_done) begin
            y_valid <= 1'b1;
        end else if (y_ready) begin
            y_valid <= 1'b0;
        end
    end

    // Payload only loads on a new result, holds under stall
    always_ff @(posedge clk) begin
        if (x_fire && win_done) begin
            y_beat.data <= clamped;
            // First output pixel sits at (2,2)
            y_beat.sof  <= (row == row_t'(2)) && (col == col_t'(2));
            y_beat.eof  <= (row == row_t'(IMG_HEIGHT - 1))
                        && (col == col_t'(IMG_WIDTH - 1));
        end
    end

endmodule

// File: frame_capture.sv
module frame_capture #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Observed filtered stream, never stalled here
    input  logic                  y_valid,
    input  logic                  y_ready,
    input  vision_pkg::pix_beat_t y_beat,

    input  logic                  capture_trigger,
    output logic                  capturing,
    output logic                  valid_to_read,

    // Replay stream to statistics
    output logic                  rd_valid,
    input  logic                  rd_ready,
    output vision_pkg::pix_beat_t rd_beat
);

    // One valid-window frame
    localparam int DEPTH = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2);

    typedef logic [$clog2(DEPTH)-1:0] addr_t;

    vision_pkg::filt_state_t state;
    vision_pkg::pixel_t      mem [DEPTH];

    addr_t wr_addr;
    addr_t rd_addr;
    logic  in_frame;
    logic  y_fire;
    logic  wr_en;
    logic  rd_fire;

    // ==============================
    // Write side
    // ==============================

    assign y_fire = y_valid && y_ready;

    // Store from the first sof after arming through eof
    assign wr_en  = (state == vision_pkg::capture) && y_fire && (in_frame || y_beat.sof);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= y_beat.data;
        end
    end

    // ==============================
    // FSM
    // ==============================

    assign rd_fire = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= vision_pkg::idle;
            in_frame <= 1'b0;
            wr_addr  <= '0;
            rd_addr  <= '0;
        end else begin
            case (state)
                vision_pkg::idle: begin
                    in_frame <= 1'b0;
                    // sof of the captured frame lands at address 0
                    wr_addr  <= '0;
                    // Arm on trigger
                    if (capture_trigger) begin
                        state <= vision_pkg::capture;
                    end
                end
                vision_pkg::capture: begin
                    if (wr_en) begin
                        wr_addr  <= wr_addr + addr_t'(1);
                        in_frame <= 1'b1;
                        // Frame complete, start replay
                        if (y_beat.eof) begin
                            state    <= vision_pkg::replay;
                            in_frame <= 1'b0;
                            rd_addr  <= '0;
                        end
                    end
                end
                vision_pkg::replay: begin
                    if (rd_fire) begin
                        if (rd_addr == addr_t'(DEPTH - 1)) begin
                            state <= vision_pkg::idle;
                        end else begin
                            rd_addr <= rd_addr + addr_t'(1);
                        end
                    end
                end
                default: state <= vision_pkg::idle;
            endcase
        end
    end

    // ==============================
    // Status and replay
    // ==============================

    // Busy from arm through last replay beat
    assign capturing     = (state != vision_pkg::idle);
    assign valid_to_read = (state == vision_pkg::replay);

    // Memory read is combinational, data stable while stalled
    assign rd_valid     = (state == vision_pkg::replay);
    assign rd_beat.data = mem[rd_addr];
    assign rd_beat.sof  = (rd_addr == '0);
    assign rd_beat.eof  = (rd_addr == addr_t'(DEPTH - 1));

endmodule

// File: pattern_cases.txt
# k0 k1 k2 k3 k4 k5 k6 k7 k8 (row-major, signed) shift threshold min_area max_area stall_pct
# shift and area bounds match the DUT parameters of the testbench
0 0 0 0 0 0 0 0 0 1 0 8 16 0
0 0 0 0 0 0 0 0 0 1 1 8 16 25
0 0 0 0 2 0 0 0 0 1 128 8 16 0
0 0 0 0 2 0 0 0 0 1 128 8 16 75
-1 0 1 -2 0 2 -1 0 1 1 64 8 16 50
-1 -2 -1 0 0 0 1 2 1 1 200 8 16 75
1 0 -1 2 0 -2 1 0 -1 1 32 8 16 10
8 8 8 8 8 8 8 8 8 1 255 8 16 75
0 0 0 0 2 0 0 0 0 1 200 8 16 40
0 0 0 0 2 0 0 0 0 1 60 8 16 0

// File: pattern_recognition.sv
module pattern_recognition #(
    parameter int IMG_WIDTH     = 640,
    parameter int IMG_HEIGHT    = 480,
    parameter int W_FRAC        = 0,
    parameter int MIN_BLOB_AREA = 500,
    parameter int MAX_BLOB_AREA = 50000
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Camera stream
    input  logic                  x_valid,
    output logic                  x_ready,
    input  vision_pkg::pixel_t    x_data,

    // Edge kernel
    input  vision_pkg::kernel_t   kernel,

    // Filtered stream out
    output logic                  y_valid,
    input  logic                  y_ready,
    output vision_pkg::pix_beat_t y_beat,

    // Capture control
    input  logic                  capture_trigger,
    output logic                  capturing,
    output logic                  valid_to_read,

    // Detection
    input  vision_pkg::pixel_t    threshold,
    output vision_pkg::count_t    white_count,
    output logic                  crossing_detected,
    output logic                  detection_valid
);

    // Replay link, capture buffer to statistics
    logic                  rd_valid;
    logic                  rd_ready;
    vision_pkg::pix_beat_t rd_beat;

    // ==============================
    // Edge filter
    // ==============================

    convolution_filter #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .W_FRAC     (W_FRAC)
    ) u_filter (
        .clk     (clk),
        .rst_n   (rst_n),
        .x_valid (x_valid),
        .x_ready (x_ready),
        .x_data  (x_data),
        .kernel  (kernel),
        .y_valid (y_valid),
        .y_ready (y_ready),
        .y_beat  (y_beat)
    );

    // Snoops the output stream
    frame_capture #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT)
    ) u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .y_valid         (y_valid),
        .y_ready         (y_ready),
        .y_beat          (y_beat),
        .capture_trigger (capture_trigger),
        .capturing       (capturing),
        .valid_to_read   (valid_to_read),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .rd_beat         (rd_beat)
    );

    // ==============================
    // Statistics
    // ==============================

    pixel_statistics #(
        .MIN_BLOB_AREA (MIN_BLOB_AREA),
        .MAX_BLOB_AREA (MAX_BLOB_AREA)
    ) u_stats (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_valid          (rd_valid),
        .rd_ready          (rd_ready),
        .rd_beat           (rd_beat),
        .threshold         (threshold),
        .white_count       (white_count),
        .crossing_detected (crossing_detected),
        .detection_valid   (detection_valid)
    );

endmodule

// File: pixel_statistics.sv
module pixel_statistics #(
    parameter int MIN_BLOB_AREA = 500,
    parameter int MAX_BLOB_AREA = 50000
) (
    input  logic                  clk,
    input  logic                  rst_n,

    // Replayed frame
    input  logic                  rd_valid,
    output logic                  rd_ready,
    input  vision_pkg::pix_beat_t rd_beat,

    input  vision_pkg::pixel_t    threshold,

    // Per-frame result
    output vision_pkg::count_t    white_count,
    output logic                  crossing_detected,
    output logic                  detection_valid
);

    vision_pkg::count_t acc;
    vision_pkg::count_t acc_nxt;
    logic               rd_fire;
    logic               hit;
    logic               in_window;

    // Never back-pressures the replay
    assign rd_ready = 1'b1;
    assign rd_fire  = rd_valid && rd_ready;

    // ==============================
    // Accumulate
    // ==============================

    // White pixel at or above threshold
    assign hit = (rd_beat.data >= threshold);

    // sof restarts the count with the current beat
    assign acc_nxt = (rd_beat.sof ? vision_pkg::count_t'(0) : acc)
                   + vision_pkg::count_t'(hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (rd_fire) begin
            acc <= acc_nxt;
        end
    end

    // Area window, both bounds inclusive
    assign in_window = (acc_nxt >= vision_pkg::count_t'(MIN_BLOB_AREA))
                    && (acc_nxt <= vision_pkg::count_t'(MAX_BLOB_AREA));

    // ==============================
    // Result
    // ==============================

    // Strobe for one cycle after eof, values held until next frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            white_count       <= '0;
            crossing_detected <= 1'b0;
            detection_valid   <= 1'b0;
        end else begin
            detection_valid <= 1'b0;
            if (rd_fire && rd_beat.eof) begin
                white_count       <= acc_nxt;
                crossing_detected <= in_window;
                detection_valid   <= 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_pattern_recognition \
    -f tb.f -o tb_sim > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 || cat build.log
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
exit 0

// File: tb.f
vision_pkg.sv
convolution_filter.sv
frame_capture.sv
pixel_statistics.sv
pattern_recognition.sv
tb_pattern_recognition.sv

// File: tb_pattern_recognition.sv
module tb_pattern_recognition;
    timeunit 1ns;
    timeprecision 100ps;

    // Small frame so each case runs fast
    localparam int IMG_WIDTH     = 8;
    localparam int IMG_HEIGHT    = 6;
    localparam int W_FRAC        = 1;
    localparam int MIN_BLOB_AREA = 8;
    localparam int MAX_BLOB_AREA = 16;
    localparam int NPIX          = IMG_WIDTH * IMG_HEIGHT;
    localparam int NOUT          = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2);

    logic                  clk = 1'b0;
    logic                  y_ready = 1'b0;
    logic                  rst_n, x_valid, x_ready, y_valid, capture_trigger;
    logic                  capturing, valid_to_read, crossing_detected, detection_valid;
    vision_pkg::pixel_t    x_data, threshold;
    vision_pkg::kernel_t   kernel;
    vision_pkg::pix_beat_t y_beat;
    vision_pkg::count_t    white_count;

    // Case table, columns k0..k8 shift thr min max stall
    int                    cs [32][14];
    int                    n_cases = 0;
    int                    seed = 10;
    int                    stall_pct = 0;
    int                    stall_seen = 0;
    int                    det_count = 0;
    logic                  det_prev = 1'b0;
    logic                  arm_pending = 1'b0;
    logic                  vtr_seen = 1'b0;
    vision_pkg::pixel_t    pix [NPIX];
    // Expected filtered beats in stream order
    vision_pkg::pix_beat_t exp_q [$];

    pattern_recognition #(
        .IMG_WIDTH     (IMG_WIDTH),
        .IMG_HEIGHT    (IMG_HEIGHT),
        .W_FRAC        (W_FRAC),
        .MIN_BLOB_AREA (MIN_BLOB_AREA),
        .MAX_BLOB_AREA (MAX_BLOB_AREA)
    ) u_dut (.*);

    always #20 clk = ~clk;

    // ==============================
    // Checks
    // ==============================

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("FAIL %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    // ==============================
    // Reference model
    // ==============================

    // Valid-window correlation, returns white count at the case threshold
    function automatic int push_reference(input int c);
        int                    sum;
        int                    cnt;
        int                    idx;
        vision_pkg::pix_beat_t b;
        cnt = 0;
        idx = 0;
        for (int r = 2; r < IMG_HEIGHT; r++) begin
            for (int x = 2; x < IMG_WIDTH; x++) begin
                sum = 0;
                // Window top-left is two rows up, two columns left
                for (int k = 0; k < 9; k++) begin
                    sum += int'(pix[(r - 2 + k / 3) * IMG_WIDTH + x - 2 + k % 3]) * cs[c][k];
                end
                sum = sum >>> cs[c][9];
                if (sum < 0) begin
                    sum = 0;
                end else if (sum > 255) begin
                    sum = 255;
                end
                b.data = vision_pkg::pixel_t'(sum);
                b.sof  = (idx == 0);
                b.eof  = (idx == NOUT - 1);
                exp_q.push_back(b);
                if (sum >= cs[c][10]) begin
                    cnt++;
                end
                idx++;
            end
        end
        return cnt;
    endfunction

    // ==============================
    // Stimulus
    // ==============================

    // Drawn on the rising edge, stall draws use the falling edge
    task automatic new_frame();
        @(posedge clk);
        for (int i = 0; i < NPIX; i++) begin
            pix[i] = vision_pkg::pixel_t'($random(seed));
        end
    endtask

    // One-cycle trigger pulse together with pixel trig_at
    task automatic send_frame(input int trig_at);
        for (int i = 0; i < NPIX; i++) begin
            @(negedge clk);
            x_valid         = 1'b1;
            x_data          = pix[i];
            capture_trigger = (i == trig_at);
            @(posedge clk);
            while (!x_ready) begin
                @(negedge clk);
                capture_trigger = 1'b0;
                @(posedge clk);
            end
        end
        @(negedge clk);
        x_valid         = 1'b0;
        capture_trigger = 1'b0;
    endtask

    // Random back-pressure on the output stream
    always @(negedge clk) begin
        y_ready = ($unsigned($random(seed)) % 100) >= stall_pct;
    end

    // ==============================
    // Monitor
    // ==============================

    always @(posedge clk) begin
        if (rst_n) begin
            // Trigger seen in idle arms on the next cycle
            if (arm_pending) begin
                check_value("capturing after trigger", int'(capturing), 1);
            end
            arm_pending = capture_trigger && !capturing;
            if (y_valid && !y_ready) begin
                check_value("x_ready while output stalled", int'(x_ready), 0);
                stall_seen++;
            end
            if (y_valid && y_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("filtered stream sent a beat that no frame expects");
                end
                check_value("y_beat {data,sof,eof}", int'(y_beat), int'(exp_q.pop_front()));
            end
            if (valid_to_read) begin
                check_value("capturing during replay", int'(capturing), 1);
                vtr_seen = 1'b1;
            end
            if (detection_valid) begin
                check_value("detection_valid held twice", int'(det_prev), 0);
                check_value("valid_to_read before detection", int'(vtr_seen), 1);
                det_count++;
            end
            det_prev = detection_valid;
        end
    end

    // Limit of three frames per case with a margin of four
    initial begin
        @(posedge rst_n);
        #(n_cases * 3 * NPIX * 40 * 4);
        $display("Timeout: the watchdog expired before the last case finished");
        $display("Regression failed");
        $fatal(1);
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        int    fd;
        int    n;
        int    cnt;
        string line;
        rst_n           = 1'b0;
        x_valid         = 1'b0;
        x_data          = '0;
        kernel          = '0;
        capture_trigger = 1'b0;
        threshold       = '0;
        fd = $fopen("pattern_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open pattern_cases.txt");
        end
        while (!$feof(fd) && n_cases < 32) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comment and blank lines
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                            cs[n_cases][0], cs[n_cases][1], cs[n_cases][2], cs[n_cases][3],
                            cs[n_cases][4], cs[n_cases][5], cs[n_cases][6], cs[n_cases][7],
                            cs[n_cases][8], cs[n_cases][9], cs[n_cases][10],
                            cs[n_cases][11], cs[n_cases][12], cs[n_cases][13]);
                if (n == 14) begin
                    n_cases++;
                end
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            abort_run("no test cases found in pattern_cases.txt");
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int c = 0; c < n_cases; c++) begin
            // Shift and area bounds are DUT parameters
            check_value("case shift", cs[c][9], W_FRAC);
            check_value("case min area", cs[c][11], MIN_BLOB_AREA);
            check_value("case max area", cs[c][12], MAX_BLOB_AREA);
            @(negedge clk);
            for (int k = 0; k < 9; k++) begin
                kernel[k] = vision_pkg::coef_t'(cs[c][k]);
            end
            threshold = vision_pkg::pixel_t'(cs[c][10]);
            stall_pct = cs[c][13];
            vtr_seen  = 1'b0;
            // Frame A, trigger half way through
            new_frame();
            void'(push_reference(c));
            send_frame(NPIX / 2);
            // Frame B is captured, extra trigger lands during capture
            new_frame();
            cnt = push_reference(c);
            send_frame(3);
            do @(posedge clk); while (!valid_to_read);
            // Trigger during replay
            @(negedge clk);
            capture_trigger = 1'b1;
            @(negedge clk);
            capture_trigger = 1'b0;
            do @(posedge clk); while (!detection_valid);
            @(negedge clk);
            check_value("white_count", int'(white_count), cnt);
            check_value("crossing_detected", int'(crossing_detected),
                        int'(cnt >= MIN_BLOB_AREA && cnt <= MAX_BLOB_AREA));
            check_value("detections so far", det_count, c + 1);
        end
        // Trailing frame exposes a wrongly accepted trigger
        new_frame();
        void'(push_reference(n_cases - 1));
        send_frame(-1);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (2 * NOUT) @(negedge clk);
        check_value("total detections", det_count, n_cases);
        check_value("capturing at end", int'(capturing), 0);
        check_value("output stalls seen", int'(stall_seen > 0), 1);
        $display("Regression passed");
        $finish;
    end

endmodule

// File: vision_pkg.sv
package vision_pkg;

    // ==============================
    // Basic widths
    // ==============================

    // Grayscale pixel
    localparam int PIX_W = 8;
    // Kernel coefficient, two's complement
    localparam int COEF_W = 8;
    // 3x3 window
    localparam int TAPS = 9;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic signed [COEF_W-1:0] coef_t;

    // Row-major kernel, element 0 is top-left and sits in bits [7:0]
    typedef coef_t [TAPS-1:0] kernel_t;

    // Pixel counter for statistics
    typedef logic [15:0] count_t;

    // ==============================
    // Stream beat
    // ==============================

    // One pixel on a stream with frame markers
    typedef struct packed {
        pixel_t data;
        // First pixel of frame
        logic   sof;
        // Last pixel of frame
        logic   eof;
    } pix_beat_t;

    // Capture buffer FSM
    typedef enum logic [1:0] {
        idle,
        capture,
        replay
    } filt_state_t;

endpackage
